//--- hdl/exe_alu.sv
/*
 * Single-cycle integer ALU.
 * Works on src1 and opnd2; word32 selects the RV64 word forms.
 */
`timescale 1ns/1ps

module exe_alu (
    exe_operand_if.unit_mp          opif,
    output exe_types_pkg::bus64_t   result_o
);
    import exe_types_pkg::*;
    import exe_ops_pkg::*;

    bus64_t     a;
    bus64_t     b;
    bus64_t     a_srl;
    bus64_t     a_sra;
    bus64_t     r;
    logic [5:0] shamt;

    assign a = opif.src1;
    assign b = opif.opnd2;

    // Word shifts use five shift bits and a 32-bit source
    assign shamt = opif.word32 ? {1'b0, b[4:0]} : b[5:0];
    assign a_srl = opif.word32 ? {32'b0, a[31:0]} : a;
    assign a_sra = opif.word32 ? {{32{a[31]}}, a[31:0]} : a;

    always_comb begin
        case (opif.alu_op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLL:  r = a << shamt;
            ALU_SRL:  r = a_srl >> shamt;
            ALU_SRA:  r = $signed(a_sra) >>> shamt;
            ALU_SLT:  r = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: r = {{(XLEN-1){1'b0}}, a < b};
            default:  r = '0;
        endcase
    end

    assign result_o = opif.word32 ? {{32{r[31]}}, r[31:0]} : r;

endmodule

//--- hdl/exe_branch.sv
/*
 * Branch unit: condition check, target address and link value.
 * Purely combinational; the control module registers its outputs.
 */
`timescale 1ns/1ps

module exe_branch (
    exe_operand_if.unit_mp          opif,
    output logic                    taken_o,
    output exe_types_pkg::addr_t    target_o,
    output exe_types_pkg::bus64_t   link_o
);
    import exe_types_pkg::*;
    import exe_ops_pkg::*;

    bus64_t jalr_sum;
    addr_t  link_pc;

    always_comb begin
        case (opif.br_op)
            BR_BEQ:  taken_o = opif.src1 == opif.src2;
            BR_BNE:  taken_o = opif.src1 != opif.src2;
            BR_BLT:  taken_o = $signed(opif.src1) <  $signed(opif.src2);
            BR_BGE:  taken_o = $signed(opif.src1) >= $signed(opif.src2);
            BR_BLTU: taken_o = opif.src1 <  opif.src2;
            BR_BGEU: taken_o = opif.src1 >= opif.src2;
            // Jumps always redirect
            default: taken_o = 1'b1;
        endcase
    end

    // jalr target has bit 0 forced low
    assign jalr_sum = opif.src1 + opif.imm;
    assign target_o = (opif.br_op == BR_JALR) ? {jalr_sum[ADDR_W-1:1], 1'b0}
                                              : opif.pc + opif.imm[ADDR_W-1:0];

    assign link_pc = opif.pc + addr_t'(4);
    assign link_o  = {{(XLEN-ADDR_W){1'b0}}, link_pc};

endmodule

//--- hdl/exe_ctrl.sv
/*
 * Execute stage control: write-back forwarding, operand select, dispatch to
 * the long units, stall generation and the registered result.
 * Short ops retire one cycle after acceptance, long ops when their unit is done.
 */
`timescale 1ns/1ps

module exe_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        valid_i,
    input  exe_ops_pkg::unit_t          unit_i,
    input  exe_types_pkg::reg_t         rd_i,
    input  exe_types_pkg::reg_t         rs1_i,
    input  exe_types_pkg::reg_t         rs2_i,
    input  exe_types_pkg::bus64_t       rs1_data_i,
    input  exe_types_pkg::bus64_t       rs2_data_i,
    input  exe_types_pkg::bus64_t       imm_i,
    input  logic                        use_imm_i,
    input  exe_types_pkg::addr_t        pc_i,
    input  exe_ops_pkg::alu_op_t        alu_op_i,
    input  exe_ops_pkg::branch_op_t     br_op_i,
    input  exe_ops_pkg::md_op_t         md_op_i,
    input  logic                        word32_i,
    input  logic                        kill_i,
    input  logic                        wb_valid_i,
    input  exe_types_pkg::reg_t         wb_rd_i,
    input  exe_types_pkg::bus64_t       wb_data_i,
    exe_operand_if.ctrl_mp              opif,
    input  exe_types_pkg::bus64_t       alu_res_i,
    input  exe_types_pkg::bus64_t       br_res_i,
    input  logic                        br_taken_i,
    input  exe_types_pkg::addr_t        br_target_i,
    input  exe_types_pkg::bus64_t       mul_res_i,
    input  logic                        mul_done_i,
    input  exe_types_pkg::bus64_t       div_res_i,
    input  logic                        div_done_i,
    input  logic                        div_busy_i,
    output logic                        mul_req_o,
    output logic                        div_req_o,
    output logic                        kill_o,
    output logic                        res_valid_o,
    output exe_types_pkg::reg_t         res_rd_o,
    output exe_types_pkg::bus64_t       res_data_o,
    output logic                        taken_o,
    output exe_types_pkg::addr_t        target_o,
    output logic                        stall_o
);
    import exe_types_pkg::*;
    import exe_ops_pkg::*;

    typedef enum logic [1:0] {IDLE, WAIT_MUL, WAIT_DIV} state_t;

    state_t state_q;
    state_t state_d;
    // Long op finished or killed; its instruction leaves this cycle
    logic   retire_q;
    logic   is_long;
    logic   issue;
    logic   short_done;
    logic   long_done;
    bus64_t res_d;

    // Bypass and operand select ---------
    assign opif.src1   = (wb_valid_i && wb_rd_i == rs1_i && rs1_i != '0) ? wb_data_i : rs1_data_i;
    assign opif.src2   = (wb_valid_i && wb_rd_i == rs2_i && rs2_i != '0) ? wb_data_i : rs2_data_i;
    assign opif.opnd2  = use_imm_i ? imm_i : opif.src2;
    assign opif.imm    = imm_i;
    assign opif.pc     = pc_i;
    assign opif.alu_op = alu_op_i;
    assign opif.br_op  = br_op_i;
    assign opif.md_op  = md_op_i;
    assign opif.word32 = word32_i;

    // Dispatch and stall ----------------
    assign is_long   = valid_i && (unit_i == UNIT_MUL || unit_i == UNIT_DIV);
    assign issue     = valid_i && state_q == IDLE && !retire_q && !kill_i;
    assign mul_req_o = issue && unit_i == UNIT_MUL;
    assign div_req_o = issue && unit_i == UNIT_DIV && !div_busy_i;
    assign kill_o    = kill_i;
    assign stall_o   = (state_q != IDLE) || (is_long && !retire_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (mul_req_o) begin
                    state_d = WAIT_MUL;
                end else if (div_req_o) begin
                    state_d = WAIT_DIV;
                end
            end
            WAIT_MUL: begin
                if (kill_i || mul_done_i) begin
                    state_d = IDLE;
                end
            end
            WAIT_DIV: begin
                if (kill_i || div_done_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // Result select ---------------------
    assign short_done = valid_i && !stall_o && (unit_i == UNIT_ALU || unit_i == UNIT_BRANCH);
    assign long_done  = !kill_i && ((state_q == WAIT_MUL && mul_done_i) ||
                                    (state_q == WAIT_DIV && div_done_i));

    always_comb begin
        case (unit_i)
            UNIT_ALU:    res_d = alu_res_i;
            UNIT_BRANCH: res_d = br_res_i;
            UNIT_MUL:    res_d = mul_res_i;
            default:     res_d = div_res_i;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            retire_q    <= 1'b0;
            res_valid_o <= 1'b0;
            taken_o     <= 1'b0;
        end else begin
            state_q     <= state_d;
            retire_q    <= (state_q != IDLE) && (state_d == IDLE);
            res_valid_o <= short_done || long_done;
            taken_o     <= short_done && unit_i == UNIT_BRANCH && br_taken_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (short_done || long_done) begin
            res_rd_o   <= rd_i;
            res_data_o <= res_d;
            target_o   <= (unit_i == UNIT_BRANCH) ? br_target_i : '0;
        end
    end

    // Neither long unit holds an operation while the FSM is idle
    a_idle_units: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == IDLE) |-> (!mul_done_i && !div_busy_i));

    a_rst_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !res_valid_o);

endmodule

//--- hdl/exe_div.sv
/*
 * Radix-2 restoring divider, one quotient bit per cycle.
 * Operands are latched on req_i; done_o pulses DIV_W+1 cycles later with the
 * sign-corrected quotient or remainder. kill_i returns it to idle.
 */
`timescale 1ns/1ps

module exe_div #(
    parameter int DIV_W = exe_types_pkg::XLEN
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    exe_operand_if.unit_mp          opif,
    input  logic                    req_i,
    input  logic                    kill_i,
    output exe_types_pkg::bus64_t   result_o,
    output logic                    done_o,
    output logic                    busy_o
);
    import exe_types_pkg::*;
    import exe_ops_pkg::*;

    localparam int CNT_W = $clog2(DIV_W + 1);

    logic             sgn_op;
    bus64_t           a_ext;
    bus64_t           b_ext;
    logic [DIV_W-1:0] a_w;
    logic [DIV_W-1:0] b_w;
    logic             a_neg;
    logic             b_neg;
    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic [DIV_W-1:0] quo_q;
    logic [DIV_W-1:0] dvsr_q;
    logic [DIV_W-1:0] rem_q;
    logic             neg_quo_q;
    logic             neg_rem_q;
    logic             sel_rem_q;
    logic             w32_q;
    logic [DIV_W:0]   shifted;
    logic [DIV_W:0]   diff;
    logic [DIV_W-1:0] res_w;
    bus64_t           res64;

    // Operand preparation ---------------
    assign sgn_op = (opif.md_op == MD_DIV) || (opif.md_op == MD_REM);
    assign a_ext  = !opif.word32 ? opif.src1 :
                    sgn_op ? {{32{opif.src1[31]}}, opif.src1[31:0]} : {32'b0, opif.src1[31:0]};
    assign b_ext  = !opif.word32 ? opif.src2 :
                    sgn_op ? {{32{opif.src2[31]}}, opif.src2[31:0]} : {32'b0, opif.src2[31:0]};
    assign a_w    = a_ext[DIV_W-1:0];
    assign b_w    = b_ext[DIV_W-1:0];
    assign a_neg  = sgn_op && a_w[DIV_W-1];
    assign b_neg  = sgn_op && b_w[DIV_W-1];

    // One restoring step
    assign shifted = {rem_q, quo_q[DIV_W-1]};
    assign diff    = shifted - {1'b0, dvsr_q};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (kill_i) begin
            busy_q <= 1'b0;
        end else if (req_i) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(DIV_W);
        end else if (busy_q) begin
            if (cnt_q == '0) begin
                busy_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            quo_q     <= a_neg ? -a_w : a_w;
            dvsr_q    <= b_neg ? -b_w : b_w;
            rem_q     <= '0;
            // Divide by zero keeps the all-ones quotient
            neg_quo_q <= (a_neg ^ b_neg) && (b_w != '0);
            neg_rem_q <= a_neg;
            sel_rem_q <= (opif.md_op == MD_REM) || (opif.md_op == MD_REMU);
            w32_q     <= opif.word32;
        end else if (busy_q && cnt_q != '0) begin
            quo_q <= {quo_q[DIV_W-2:0], ~diff[DIV_W]};
            rem_q <= diff[DIV_W] ? shifted[DIV_W-1:0] : diff[DIV_W-1:0];
        end
    end

    // Sign correction and result select
    assign res_w    = sel_rem_q ? (neg_rem_q ? -rem_q : rem_q)
                                : (neg_quo_q ? -quo_q : quo_q);
    assign res64    = bus64_t'(res_w);
    assign result_o = w32_q ? {{32{res64[31]}}, res64[31:0]} : res64;
    assign done_o   = busy_q && (cnt_q == '0);
    assign busy_o   = busy_q;

    // The control module must wait for the running division
    a_no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i |-> !busy_o);

endmodule

//--- hdl/exe_mul.sv
/*
 * Pipelined multiplier with MUL_STAGES register stages.
 * A request captures the product of the current operands; done_o marks the
 * result leaving the last stage. kill_i drops every product in flight.
 */
`timescale 1ns/1ps

module exe_mul #(
    parameter int MUL_STAGES = 3
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    exe_operand_if.unit_mp          opif,
    input  logic                    req_i,
    input  logic                    kill_i,
    output exe_types_pkg::bus64_t   result_o,
    output logic                    done_o
);
    import exe_types_pkg::*;
    import exe_ops_pkg::*;

    logic                     a_sgn;
    logic                     b_sgn;
    logic signed [XLEN:0]     a_s;
    logic signed [XLEN:0]     b_s;
    logic signed [2*XLEN+1:0] prod;
    bus64_t                   sel;
    bus64_t                   pipe_q [MUL_STAGES];
    logic [MUL_STAGES-1:0]    vld_q;

    // One extra bit per operand covers signed, unsigned and mixed forms
    assign a_sgn = (opif.md_op == MD_MULH) || (opif.md_op == MD_MULHSU);
    assign b_sgn = (opif.md_op == MD_MULH);
    assign a_s   = {a_sgn & opif.src1[XLEN-1], opif.src1};
    assign b_s   = {b_sgn & opif.src2[XLEN-1], opif.src2};
    assign prod  = a_s * b_s;

    always_comb begin
        if (opif.word32) begin
            sel = {{32{prod[31]}}, prod[31:0]};
        end else if (opif.md_op == MD_MUL) begin
            sel = prod[XLEN-1:0];
        end else begin
            sel = prod[2*XLEN-1:XLEN];
        end
    end

    // Valid bits -------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else if (kill_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= (vld_q << 1) | MUL_STAGES'(req_i);
        end
    end

    always_ff @(posedge clk_i) begin
        pipe_q[0] <= sel;
        for (int i = 1; i < MUL_STAGES; i++) begin
            pipe_q[i] <= pipe_q[i-1];
        end
    end

    assign result_o = pipe_q[MUL_STAGES-1];
    assign done_o   = vld_q[MUL_STAGES-1];

endmodule

//--- hdl/exe_operand_if.sv
/*
 * Operand bundle from the control module to the functional units.
 * exe_ctrl drives it through ctrl_mp, every unit reads it through unit_mp.
 */
`timescale 1ns/1ps

interface exe_operand_if;
    import exe_types_pkg::*;
    import exe_ops_pkg::*;

    bus64_t     src1;
    bus64_t     src2;
    // Immediate or src2, picked by use_imm
    bus64_t     opnd2;
    bus64_t     imm;
    addr_t      pc;
    alu_op_t    alu_op;
    branch_op_t br_op;
    md_op_t     md_op;
    logic       word32;

    modport ctrl_mp (output src1, src2, opnd2, imm, pc, alu_op, br_op, md_op, word32);
    modport unit_mp (input  src1, src2, opnd2, imm, pc, alu_op, br_op, md_op, word32);

endinterface

//--- hdl/exe_ops_pkg.sv
/*
 * Operation encodings for the execute stage.
 * Decode produces these values and the functional units consume them.
 */

package exe_ops_pkg;

    // Functional unit select
    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_BRANCH = 2'd1,
        UNIT_MUL    = 2'd2,
        UNIT_DIV    = 2'd3
    } unit_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0, ALU_SUB  = 4'd1, ALU_AND  = 4'd2, ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4, ALU_SLL  = 4'd5, ALU_SRL  = 4'd6, ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8, ALU_SLTU = 4'd9
    } alu_op_t;

    // Conditional branches first, then the two jumps
    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0, BR_BNE  = 3'd1, BR_BLT = 3'd2, BR_BGE  = 3'd3,
        BR_BLTU = 3'd4, BR_BGEU = 3'd5, BR_JAL = 3'd6, BR_JALR = 3'd7
    } branch_op_t;

    // Multiply forms share the encoding space with divide forms
    typedef enum logic [2:0] {
        MD_MUL = 3'd0, MD_MULH = 3'd1, MD_MULHU = 3'd2, MD_MULHSU = 3'd3,
        MD_DIV = 3'd4, MD_DIVU = 3'd5, MD_REM   = 3'd6, MD_REMU   = 3'd7
    } md_op_t;

endpackage

//--- hdl/exe_top.sv
/*
 * Execute stage top level.
 * Connects the control module to the ALU, branch, multiply and divide units
 * and passes the unit parameters down.
 */
`timescale 1ns/1ps

module exe_top #(
    parameter int MUL_STAGES = 3,
    parameter int DIV_W      = exe_types_pkg::XLEN
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        valid_i,
    input  exe_ops_pkg::unit_t          unit_i,
    input  exe_types_pkg::reg_t         rd_i,
    input  exe_types_pkg::reg_t         rs1_i,
    input  exe_types_pkg::reg_t         rs2_i,
    input  exe_types_pkg::bus64_t       rs1_data_i,
    input  exe_types_pkg::bus64_t       rs2_data_i,
    input  exe_types_pkg::bus64_t       imm_i,
    input  logic                        use_imm_i,
    input  exe_types_pkg::addr_t        pc_i,
    input  exe_ops_pkg::alu_op_t        alu_op_i,
    input  exe_ops_pkg::branch_op_t     br_op_i,
    input  exe_ops_pkg::md_op_t         md_op_i,
    input  logic                        word32_i,
    input  logic                        kill_i,
    input  logic                        wb_valid_i,
    input  exe_types_pkg::reg_t         wb_rd_i,
    input  exe_types_pkg::bus64_t       wb_data_i,
    output logic                        res_valid_o,
    output exe_types_pkg::reg_t         res_rd_o,
    output exe_types_pkg::bus64_t       res_data_o,
    output logic                        taken_o,
    output exe_types_pkg::addr_t        target_o,
    output logic                        stall_o
);
    import exe_types_pkg::*;

    bus64_t alu_res;
    bus64_t br_res;
    logic   br_taken;
    addr_t  br_target;
    bus64_t mul_res;
    logic   mul_done;
    bus64_t div_res;
    logic   div_done;
    logic   div_busy;
    logic   mul_req;
    logic   div_req;
    logic   kill;

    exe_operand_if opif ();

    exe_ctrl ctrl0 (
        .clk_i       (clk_i),       .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),     .unit_i      (unit_i),
        .rd_i        (rd_i),        .rs1_i       (rs1_i),       .rs2_i (rs2_i),
        .rs1_data_i  (rs1_data_i),  .rs2_data_i  (rs2_data_i),
        .imm_i       (imm_i),       .use_imm_i   (use_imm_i),   .pc_i  (pc_i),
        .alu_op_i    (alu_op_i),    .br_op_i     (br_op_i),
        .md_op_i     (md_op_i),     .word32_i    (word32_i),    .kill_i (kill_i),
        .wb_valid_i  (wb_valid_i),  .wb_rd_i     (wb_rd_i),     .wb_data_i (wb_data_i),
        .opif        (opif),
        .alu_res_i   (alu_res),     .br_res_i    (br_res),
        .br_taken_i  (br_taken),    .br_target_i (br_target),
        .mul_res_i   (mul_res),     .mul_done_i  (mul_done),
        .div_res_i   (div_res),     .div_done_i  (div_done),    .div_busy_i (div_busy),
        .mul_req_o   (mul_req),     .div_req_o   (div_req),     .kill_o (kill),
        .res_valid_o (res_valid_o), .res_rd_o    (res_rd_o),    .res_data_o (res_data_o),
        .taken_o     (taken_o),     .target_o    (target_o),    .stall_o (stall_o)
    );

    exe_alu alu0 (
        .opif     (opif),
        .result_o (alu_res)
    );

    exe_branch branch0 (
        .opif     (opif),
        .taken_o  (br_taken),
        .target_o (br_target),
        .link_o   (br_res)
    );

    exe_mul #(.MUL_STAGES(MUL_STAGES)) mul0 (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .opif     (opif),
        .req_i    (mul_req),
        .kill_i   (kill),
        .result_o (mul_res),
        .done_o   (mul_done)
    );

    exe_div #(.DIV_W(DIV_W)) div0 (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .opif     (opif),
        .req_i    (div_req),
        .kill_i   (kill),
        .result_o (div_res),
        .done_o   (div_done),
        .busy_o   (div_busy)
    );

endmodule

//--- hdl/exe_types_pkg.sv
/*
 * Data widths and vector types for the execute stage.
 * Import it in any block that handles operands, addresses or register numbers.
 */

package exe_types_pkg;

    // Integer register width
    localparam int XLEN   = 64;
    // Physical address width of the core
    localparam int ADDR_W = 40;
    localparam int REG_W  = 5;

    typedef logic [XLEN-1:0]   bus64_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [REG_W-1:0]  reg_t;

endpackage

//--- run.sh
#!/bin/sh
# Build the execute stage testbench with Verilator and run it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_exe -f tb.f -Mdir obj_dir -o sim_exe
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_exe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- tb.f
hdl/exe_types_pkg.sv
hdl/exe_ops_pkg.sv
hdl/exe_operand_if.sv
hdl/exe_alu.sv
hdl/exe_branch.sv
hdl/exe_mul.sv
hdl/exe_div.sv
hdl/exe_ctrl.sv
hdl/exe_top.sv
test/tb_exe.sv

//--- test/exe_trace.txt
# unit rd rs1 rs2 rs1_data rs2_data imm use_imm pc op word32 wb_valid wb_rd wb_data kill
# exp_data exp_taken exp_target; all hex, op is the ALU, branch or mul/div code of the unit
0 03 01 02 1234 ff0 0 0 0 0 0 0 00 0 0 2224 0 0
0 04 01 00 5 0 7 1 0 1 0 0 00 0 0 fffffffffffffffe 0 0
0 05 01 02 ff00ff f0f0f 0 0 0 2 0 0 00 0 0 f000f 0 0
0 06 01 00 a0 0 5 1 0 3 0 0 00 0 0 a5 0 0
0 07 01 02 ffff ff 0 0 0 4 0 0 00 0 0 ff00 0 0
0 08 01 00 1 0 1f 1 0 5 1 0 00 0 0 ffffffff80000000 0 0
0 09 01 00 8000000000000000 0 4 1 0 6 0 0 00 0 0 800000000000000 0 0
0 0a 01 00 80000000 0 4 1 0 7 1 0 00 0 0 fffffffff8000000 0 0
0 0b 01 02 ffffffffffffffff 1 0 0 0 8 0 0 00 0 0 1 0 0
0 0c 01 02 ffffffffffffffff 1 0 0 0 9 0 0 00 0 0 0 0 0
0 0d 01 02 7fffffff 1 0 0 0 0 1 0 00 0 0 ffffffff80000000 0 0
0 0e 05 06 10 1 0 0 0 0 0 1 05 100 0 101 0 0
0 0f 07 08 50 10 0 0 0 1 0 1 08 20 0 30 0 0
0 10 00 09 0 3 0 0 0 0 0 1 00 55 0 3 0 0
1 11 01 02 5 5 10 0 1000 0 0 0 00 0 0 1004 1 1010
1 12 01 02 1 ffffffffffffffff fffffffffffffff0 0 2000 2 0 0 00 0 0 2004 0 1ff0
1 13 01 02 1 ffffffffffffffff 8 0 3000 4 0 0 00 0 0 3004 1 3008
1 14 00 00 0 0 100 0 4000 6 0 0 00 0 0 4004 1 4100
1 15 01 00 0 0 6 0 6000 7 0 1 01 5001 0 6004 1 5006
2 16 01 02 fffffffffffffffd 7 0 0 0 0 0 0 00 0 0 ffffffffffffffeb 0 0
2 17 01 02 8000000000000000 2 0 0 0 1 0 0 00 0 0 ffffffffffffffff 0 0
2 18 01 02 ffffffffffffffff ffffffffffffffff 0 0 0 2 0 0 00 0 0 fffffffffffffffe 0 0
2 19 01 02 ffffffffffffffff ffffffffffffffff 0 0 0 3 0 0 00 0 0 ffffffffffffffff 0 0
3 1a 01 02 fffffffffffffff9 2 0 0 0 4 0 0 00 0 0 fffffffffffffffd 0 0
3 1b 01 02 fffffffffffffff9 2 0 0 0 6 0 0 00 0 0 ffffffffffffffff 0 0
3 1c 01 02 64 7 0 0 0 5 0 0 00 0 0 e 0 0
3 1d 01 02 5 0 0 0 0 7 0 0 00 0 0 5 0 0
3 1e 01 02 fffffffffffffffb 0 0 0 0 4 0 0 00 0 0 ffffffffffffffff 0 0
3 1f 01 02 8000000000000000 ffffffffffffffff 0 0 0 4 0 0 00 0 0 8000000000000000 0 0
3 01 01 02 ffffffe0 5 0 0 0 4 1 0 00 0 0 fffffffffffffffa 0 0
3 02 01 02 64 3 0 0 0 4 0 0 00 0 1 0 0 0
0 03 01 02 2 3 0 0 0 0 0 0 00 0 0 5 0 0

//--- test/tb_exe.sv
/*
 * Trace-driven testbench for the execute stage.
 * Loads test/exe_trace.txt, applies one instruction at a time to exe_top and
 * checks result, branch outcome, stall behavior and result latency.
 */
`timescale 1ns/1ps

module tb_exe;
    import exe_types_pkg::*;
    import exe_ops_pkg::*;

    localparam int MUL_STAGES = 3;
    localparam int DIV_W      = XLEN;
    localparam int RST_CYCLES = 10;

    // One trace record, stimulus first, then expected values
    typedef struct packed {
        logic [1:0] unit;
        reg_t       rd;
        reg_t       rs1;
        reg_t       rs2;
        bus64_t     rs1_data;
        bus64_t     rs2_data;
        bus64_t     imm;
        logic       use_imm;
        addr_t      pc;
        logic [3:0] op;
        logic       word32;
        logic       wb_valid;
        reg_t       wb_rd;
        bus64_t     wb_data;
        logic       kill;
        bus64_t     exp_data;
        logic       exp_taken;
        addr_t      exp_target;
    } rec_t;

    logic       clk_i;
    logic       rst_n_i;
    logic       valid_i;
    unit_t      unit_i;
    reg_t       rd_i, rs1_i, rs2_i, wb_rd_i, res_rd_o;
    bus64_t     rs1_data_i, rs2_data_i, imm_i, wb_data_i, res_data_o;
    logic       use_imm_i, word32_i, kill_i, wb_valid_i;
    addr_t      pc_i, target_o;
    alu_op_t    alu_op_i;
    branch_op_t br_op_i;
    md_op_t     md_op_i;
    logic       res_valid_o, taken_o, stall_o;

    rec_t trace_q[$];
    int   errors;
    int   checks;
    int   cycle_cnt;
    int   cycle_limit;

    exe_top #(.MUL_STAGES(MUL_STAGES), .DIV_W(DIV_W)) dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Helpers ----------------------------
    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        logic [63:0] f [18];
        rec_t        r;
        fd = $fopen("test/exe_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file test/exe_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines carry no record
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
                if (n != 18) begin
                    errors++;
                    $display("malformed trace line: %s", line);
                end else begin
                    r.unit       = f[0][1:0];
                    r.rd         = f[1][4:0];
                    r.rs1        = f[2][4:0];
                    r.rs2        = f[3][4:0];
                    r.rs1_data   = f[4];
                    r.rs2_data   = f[5];
                    r.imm        = f[6];
                    r.use_imm    = f[7][0];
                    r.pc         = f[8][ADDR_W-1:0];
                    r.op         = f[9][3:0];
                    r.word32     = f[10][0];
                    r.wb_valid   = f[11][0];
                    r.wb_rd      = f[12][4:0];
                    r.wb_data    = f[13];
                    r.kill       = f[14][0];
                    r.exp_data   = f[15];
                    r.exp_taken  = f[16][0];
                    r.exp_target = f[17][ADDR_W-1:0];
                    trace_q.push_back(r);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_result(input rec_t r, input int edges);
        compare_value("res_rd_o", res_rd_o, r.rd);
        compare_value("res_data_o", res_data_o, r.exp_data);
        compare_value("taken_o", taken_o, r.exp_taken);
        compare_value("target_o", target_o, r.exp_target);
        compare_value("stall_o", stall_o, 1'b0);
        // Divide latency is not counted, only waited for
        if (r.unit == UNIT_MUL) begin
            compare_value("res_valid_o latency", edges, MUL_STAGES + 1);
        end else if (r.unit != UNIT_DIV) begin
            compare_value("res_valid_o latency", edges, 1);
        end
    endtask

    // Present one instruction and follow it to its result or its kill
    task automatic apply_instr(input rec_t r);
        int edges;
        bit done;
        @(negedge clk_i);
        if (res_valid_o) begin
            errors++;
            $display("res_valid_o high at %0d ns with no instruction pending", $time);
        end
        unit_i     = unit_t'(r.unit);
        rd_i       = r.rd;
        rs1_i      = r.rs1;
        rs2_i      = r.rs2;
        rs1_data_i = r.rs1_data;
        rs2_data_i = r.rs2_data;
        imm_i      = r.imm;
        use_imm_i  = r.use_imm;
        pc_i       = r.pc;
        alu_op_i   = alu_op_t'(r.op);
        br_op_i    = branch_op_t'(r.op[2:0]);
        md_op_i    = md_op_t'(r.op[2:0]);
        word32_i   = r.word32;
        wb_valid_i = r.wb_valid;
        wb_rd_i    = r.wb_rd;
        wb_data_i  = r.wb_data;
        valid_i    = 1'b1;
        edges      = 0;
        done       = 1'b0;
        // Long ops stall already in the cycle they are presented
        #1;
        if (r.unit == UNIT_MUL || r.unit == UNIT_DIV) begin
            compare_value("stall_o", stall_o, 1'b1);
        end else begin
            compare_value("stall_o", stall_o, 1'b0);
        end
        while (!done) begin
            @(posedge clk_i);
            edges++;
            @(negedge clk_i);
            if (r.kill && edges == 3) begin
                compare_value("res_valid_o", res_valid_o, 1'b0);
                compare_value("stall_o", stall_o, 1'b0);
                done = 1'b1;
            end else if (res_valid_o) begin
                if (r.kill) begin
                    errors++;
                    $display("a killed divide returned a result at %0d ns", $time);
                end else begin
                    check_result(r, edges);
                end
                done = 1'b1;
            end else if (!stall_o) begin
                errors++;
                $display("stall_o dropped at %0d ns before the result arrived", $time);
                done = 1'b1;
            end else if (r.kill && edges == 2) begin
                kill_i = 1'b1;
            end
        end
        valid_i    = 1'b0;
        kill_i     = 1'b0;
        wb_valid_i = 1'b0;
    endtask

    // Main sequence ----------------------
    initial begin
        rst_n_i     = 1'b0;
        valid_i     = 1'b0;
        unit_i      = UNIT_ALU;
        rd_i        = '0;
        rs1_i       = '0;
        rs2_i       = '0;
        rs1_data_i  = '0;
        rs2_data_i  = '0;
        imm_i       = '0;
        use_imm_i   = 1'b0;
        pc_i        = '0;
        alu_op_i    = ALU_ADD;
        br_op_i     = BR_BEQ;
        md_op_i     = MD_MUL;
        word32_i    = 1'b0;
        kill_i      = 1'b0;
        wb_valid_i  = 1'b0;
        wb_rd_i     = '0;
        wb_data_i   = '0;
        errors      = 0;
        checks      = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;

        load_trace();
        if (trace_q.size() == 0) begin
            errors++;
            $display("no instructions were loaded from the trace file");
        end else begin
            // Each record needs at most DIV_W+2 cycles plus a bubble
            cycle_limit = trace_q.size() * (DIV_W + 8) + RST_CYCLES;
            repeat (RST_CYCLES) @(posedge clk_i);
            @(negedge clk_i);
            compare_value("res_valid_o", res_valid_o, 1'b0);
            compare_value("stall_o", stall_o, 1'b0);
            compare_value("taken_o", taken_o, 1'b0);
            rst_n_i = 1'b1;
            foreach (trace_q[i]) begin
                apply_instr(trace_q[i]);
            end
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles before the trace was finished", cycle_cnt);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
